/* src/aluPkg.sv */
package aluPkg;

  // Datapath widths
  localparam int dataWidth = 32;
  localparam int opWidth = 6;
  // Flags from the top bit down are saturated, negative, zero, carry and overflow
  localparam int flagsWidth = 5;

  // Arithmetic class
  localparam logic [opWidth-1:0] opAdd   = 6'b100000;
  localparam logic [opWidth-1:0] opAdc   = 6'b100001;
  localparam logic [opWidth-1:0] opQadd  = 6'b100010;
  localparam logic [opWidth-1:0] opSub   = 6'b100011;
  localparam logic [opWidth-1:0] opSbc   = 6'b100100;
  localparam logic [opWidth-1:0] opRsb   = 6'b100101;
  localparam logic [opWidth-1:0] opQsub  = 6'b100110;
  localparam logic [opWidth-1:0] opMul   = 6'b100111;
  localparam logic [opWidth-1:0] opMla   = 6'b101000;
  localparam logic [opWidth-1:0] opMls   = 6'b101001;
  localparam logic [opWidth-1:0] opUmull = 6'b101010;
  localparam logic [opWidth-1:0] opUmlal = 6'b101011;
  localparam logic [opWidth-1:0] opSmull = 6'b101100;
  localparam logic [opWidth-1:0] opSmlal = 6'b101101;
  localparam logic [opWidth-1:0] opUdiv  = 6'b101110;
  localparam logic [opWidth-1:0] opSdiv  = 6'b101111;

  // Logic, compare, move and shift class
  localparam logic [opWidth-1:0] opAnd   = 6'b110000;
  localparam logic [opWidth-1:0] opBic   = 6'b110001;
  localparam logic [opWidth-1:0] opOrr   = 6'b110010;
  localparam logic [opWidth-1:0] opOrn   = 6'b110011;
  localparam logic [opWidth-1:0] opEor   = 6'b110100;
  localparam logic [opWidth-1:0] opCmn   = 6'b110101;
  localparam logic [opWidth-1:0] opTst   = 6'b110110;
  localparam logic [opWidth-1:0] opTeq   = 6'b110111;
  localparam logic [opWidth-1:0] opCmp   = 6'b111000;
  localparam logic [opWidth-1:0] opMov   = 6'b111001;
  localparam logic [opWidth-1:0] opLsr   = 6'b111010;
  localparam logic [opWidth-1:0] opAsr   = 6'b111011;
  localparam logic [opWidth-1:0] opLsl   = 6'b111100;
  localparam logic [opWidth-1:0] opRor   = 6'b111101;
  localparam logic [opWidth-1:0] opRrx   = 6'b111110;
  localparam logic [opWidth-1:0] opEon   = 6'b111111;

  // Branch class
  localparam logic [opWidth-1:0] opB     = 6'b010000;
  localparam logic [opWidth-1:0] opCbz   = 6'b010010;
  localparam logic [opWidth-1:0] opCbnz  = 6'b010011;

  // Top two code bits
  localparam logic [1:0] clsBranch = 2'b01;
  localparam logic [1:0] clsArith  = 2'b10;
  localparam logic [1:0] clsLogic  = 2'b11;

  typedef struct packed {
    logic [1:0] opClass;
    logic [3:0] func;
  } aluOpFields;

  // Whole code for the datapath, class and function for the sequencer
  typedef union packed {
    logic [opWidth-1:0] raw;
    aluOpFields fields;
  } aluOpU;

  // Word addresses on the bus
  localparam logic [2:0] regA      = 3'd0;
  localparam logic [2:0] regB      = 3'd1;
  localparam logic [2:0] regRdLo   = 3'd2;
  localparam logic [2:0] regRdHiRa = 3'd3;
  localparam logic [2:0] regCbzRn  = 3'd4;
  localparam logic [2:0] regCtrl   = 3'd5;
  localparam logic [2:0] regResLo  = 3'd6;
  localparam logic [2:0] regResHi  = 3'd7;

  // Control word layout
  localparam int ctrlOpLsb    = 0;
  localparam int ctrlCarryBit = 8;
  localparam int ctrlBusyBit  = 16;
  localparam int ctrlFlagsLsb = 20;

endpackage

/* src/alu.sv */
module alu (
  input  logic [aluPkg::dataWidth-1:0]  a,
  input  logic [aluPkg::dataWidth-1:0]  b,
  input  logic [aluPkg::dataWidth-1:0]  rdLo,
  input  logic [aluPkg::dataWidth-1:0]  rdHiRa,
  input  logic [aluPkg::dataWidth-1:0]  cbzRn,
  input  logic [aluPkg::dataWidth-1:0]  quot,
  input  aluPkg::aluOpU                 op,
  input  logic                          carryIn,
  output logic [63:0]                   result,
  output logic [aluPkg::flagsWidth-1:0] flags
);
  import aluPkg::*;

  logic [dataWidth:0]   sum;
  logic [dataWidth:0]   diff;
  logic [dataWidth:0]   sumC;
  logic [dataWidth:0]   diffC;
  logic [dataWidth:0]   revDiff;
  logic [4:0]           shAmt;
  logic [63:0]          prodU;
  logic [63:0]          prodS;
  logic [dataWidth:0]   lslWide;
  logic [dataWidth:0]   rshWide;
  logic                 addOvf;
  logic                 subOvf;
  logic [dataWidth-1:0] resLo;
  logic [dataWidth-1:0] resHi;
  logic                 saturated;
  logic                 carry;
  logic                 overflow;

  // 33-bit forms keep the carry or borrow in the top bit
  assign sum     = {1'b0, a} + {1'b0, b};
  assign diff    = {1'b0, a} - {1'b0, b};
  assign sumC    = sum + {{dataWidth{1'b0}}, carryIn};
  assign diffC   = diff - {{dataWidth{1'b0}}, ~carryIn};
  assign revDiff = {1'b0, b} - {1'b0, a};
  assign shAmt   = b[4:0];

  assign prodU = {32'b0, a} * {32'b0, b};
  // Low 64 bits of the sign-extended product are the signed product
  assign prodS = {{32{a[31]}}, a} * {{32{b[31]}}, b};

  assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
  assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

  // One extra bit beside the word catches the last bit shifted out
  assign lslWide = {1'b0, a} << shAmt;
  assign rshWide = {a, 1'b0} >> shAmt;

  always_comb begin
    resLo = '0;
    resHi = '0;
    case (op.raw)
      opAdd:   resLo = sum[31:0];
      opAdc:   resLo = sumC[31:0];
      opQadd:  resLo = addOvf ? (a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF) : sum[31:0];
      opSub:   resLo = diff[31:0];
      opSbc:   resLo = diffC[31:0];
      opRsb:   resLo = revDiff[31:0];
      opQsub:  resLo = subOvf ? (a[31] ? 32'h8000_0000 : 32'h7FFF_FFFF) : diff[31:0];
      opMul:   resLo = prodU[31:0];
      opMla:   resLo = rdHiRa + prodU[31:0];
      opMls:   resLo = rdHiRa - prodU[31:0];
      opUmull: {resHi, resLo} = prodU;
      opUmlal: {resHi, resLo} = {rdHiRa, rdLo} + prodU;
      opSmull: {resHi, resLo} = prodS;
      opSmlal: {resHi, resLo} = {rdHiRa, rdLo} + prodS;
      opUdiv,
      opSdiv:  resLo = quot;
      opAnd:   resLo = a & b;
      opBic:   resLo = a & ~b;
      opOrr:   resLo = a | b;
      opOrn:   resLo = a | ~b;
      opEor:   resLo = a ^ b;
      opEon:   resLo = a ^ ~b;
      opCmn:   resLo = sum[31:0];
      opTst:   resLo = a & b;
      opTeq:   resLo = a ^ b;
      opCmp:   resLo = diff[31:0];
      opMov:   resLo = b;
      opLsl:   resLo = lslWide[31:0];
      opLsr:   resLo = rshWide[32:1];
      opAsr:   resLo = $signed(a) >>> shAmt;
      opRor:   resLo = (a >> shAmt) | (a << (6'd32 - {1'b0, shAmt}));
      opRrx:   resLo = {carryIn, a[31:1]};
      opB:     resLo = sum[31:0];
      // Taken branch adds the offset, otherwise falls through to A
      opCbz:   resLo = (cbzRn == '0) ? sum[31:0] : a;
      opCbnz:  resLo = (cbzRn != '0) ? sum[31:0] : a;
      default: resLo = '0;
    endcase
  end

  always_comb begin
    saturated = 1'b0;
    carry     = 1'b0;
    overflow  = 1'b0;
    case (op.raw)
      opAdd, opCmn: begin
        carry    = sum[32];
        overflow = addOvf;
      end
      opAdc: begin
        carry    = sumC[32];
        overflow = (a[31] == b[31]) && (sumC[31] != a[31]);
      end
      opQadd: begin
        saturated = addOvf;
        overflow  = addOvf;
      end
      opSub, opCmp: begin
        carry    = diff[32];
        overflow = subOvf;
      end
      opSbc: begin
        carry    = diffC[32];
        overflow = (a[31] != b[31]) && (diffC[31] != a[31]);
      end
      opRsb: begin
        carry    = revDiff[32];
        overflow = (a[31] != b[31]) && (revDiff[31] != b[31]);
      end
      opQsub: begin
        saturated = subOvf;
        overflow  = subOvf;
      end
      opLsl:               carry = lslWide[32];
      opLsr, opAsr, opRor: carry = rshWide[0];
      opRrx:               carry = a[0];
      default:             carry = 1'b0;
    endcase
  end

  assign result = {resHi, resLo};
  assign flags  = {saturated, resLo[31], (result == 64'b0), carry, overflow};

endmodule

/* src/seqDivider.sv */
module seqDivider (
  input  logic        clk,
  input  logic        arstN,
  input  logic        divStart,
  input  logic        signedDiv,
  input  logic [31:0] dividend,
  input  logic [31:0] divisor,
  output logic [31:0] quot,
  output logic        divDone
);

  logic [31:0] absDividend;
  logic [31:0] absDivisor;
  logic [31:0] den;
  logic [31:0] q;
  logic [31:0] rem;
  logic [32:0] remShift;
  logic        fits;
  logic [31:0] remNext;
  logic [31:0] qNext;
  logic [4:0]  count;
  logic        running;
  logic        negQ;
  logic        denZero;

  // Magnitudes for the signed case
  assign absDividend = (signedDiv && dividend[31]) ? -dividend : dividend;
  assign absDivisor  = (signedDiv && divisor[31]) ? -divisor : divisor;

  // One restoring step
  assign remShift = {rem, q[31]};
  assign fits     = (remShift >= {1'b0, den});
  assign remNext  = fits ? (remShift[31:0] - den) : remShift[31:0];
  assign qNext    = {q[30:0], fits};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      den     <= '0;
      q       <= '0;
      rem     <= '0;
      count   <= '0;
      running <= 1'b0;
      negQ    <= 1'b0;
      denZero <= 1'b0;
      quot    <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= 1'b0;
      if (divStart) begin
        q       <= absDividend;
        den     <= absDivisor;
        rem     <= '0;
        negQ    <= signedDiv & (dividend[31] ^ divisor[31]);
        denZero <= (divisor == '0);
        count   <= '0;
        running <= 1'b1;
      end else if (running) begin
        q     <= qNext;
        rem   <= remNext;
        count <= count + 5'd1;
        // Last step also applies the sign and the zero-divisor rule
        if (count == 5'd31) begin
          running <= 1'b0;
          divDone <= 1'b1;
          quot    <= denZero ? '0 : (negQ ? -qNext : qNext);
        end
      end
    end
  end

endmodule

/* src/aluExec.sv */
module aluExec (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          start,
  input  logic                          carryIn,
  input  aluPkg::aluOpU                 op,
  input  logic [aluPkg::dataWidth-1:0]  opA,
  input  logic [aluPkg::dataWidth-1:0]  opB,
  input  logic [aluPkg::dataWidth-1:0]  rdLo,
  input  logic [aluPkg::dataWidth-1:0]  rdHiRa,
  input  logic [aluPkg::dataWidth-1:0]  cbzRn,
  output logic                          busy,
  output logic [aluPkg::dataWidth-1:0]  resLo,
  output logic [aluPkg::dataWidth-1:0]  resHi,
  output logic [aluPkg::flagsWidth-1:0] flags
);
  import aluPkg::*;

  logic                  dividing;
  logic                  isDiv;
  logic                  divStart;
  logic                  divDone;
  logic [dataWidth-1:0]  quot;
  logic [63:0]           aluResult;
  logic [flagsWidth-1:0] aluFlags;

  // UDIV and SDIV share the arithmetic class with func 111x
  assign isDiv = (op.fields.opClass == clsArith) && (op.fields.func[3:1] == 3'b111);

  alu uAlu (
    .a       (opA),
    .b       (opB),
    .rdLo    (rdLo),
    .rdHiRa  (rdHiRa),
    .cbzRn   (cbzRn),
    .quot    (quot),
    .op      (op),
    .carryIn (carryIn),
    .result  (aluResult),
    .flags   (aluFlags)
  );

  seqDivider uDiv (
    .clk       (clk),
    .arstN     (arstN),
    .divStart  (divStart),
    .signedDiv (op.fields.func[0]),
    .dividend  (opA),
    .divisor   (opB),
    .quot      (quot),
    .divDone   (divDone)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy     <= 1'b0;
      dividing <= 1'b0;
      divStart <= 1'b0;
      resLo    <= '0;
      resHi    <= '0;
      flags    <= '0;
    end else begin
      divStart <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy     <= 1'b1;
          dividing <= isDiv;
          divStart <= isDiv;
        end
      end else if (!dividing || divDone) begin
        // Result held until the next completion
        resLo    <= aluResult[31:0];
        resHi    <= aluResult[63:32];
        flags    <= aluFlags;
        busy     <= 1'b0;
        dividing <= 1'b0;
      end
    end
  end

endmodule

/* src/aluRegs.sv */
module aluRegs (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          wbCyc,
  input  logic                          wbStb,
  input  logic                          wbWe,
  input  logic [2:0]                    wbAdr,
  input  logic [aluPkg::dataWidth-1:0]  wbDatW,
  input  logic                          busy,
  input  logic [aluPkg::dataWidth-1:0]  resLo,
  input  logic [aluPkg::dataWidth-1:0]  resHi,
  input  logic [aluPkg::flagsWidth-1:0] flags,
  output logic [aluPkg::dataWidth-1:0]  wbDatR,
  output logic                          wbAck,
  output logic                          start,
  output aluPkg::aluOpU                 op,
  output logic                          carryIn,
  output logic [aluPkg::dataWidth-1:0]  opA,
  output logic [aluPkg::dataWidth-1:0]  opB,
  output logic [aluPkg::dataWidth-1:0]  rdLo,
  output logic [aluPkg::dataWidth-1:0]  rdHiRa,
  output logic [aluPkg::dataWidth-1:0]  cbzRn
);
  import aluPkg::*;

  logic                 req;
  logic                 newReq;
  logic                 wrAcc;
  logic                 lock;
  logic [dataWidth-1:0] ctrlWord;
  logic [dataWidth-1:0] rdData;

  assign req    = wbCyc & wbStb;
  // Only the first cycle of a request is acted on
  assign newReq = req & ~wbAck;
  assign wrAcc  = newReq & wbWe;
  // Start already pending counts as busy
  assign lock   = busy | start;

  always_comb begin
    ctrlWord = '0;
    ctrlWord[ctrlOpLsb +: opWidth]       = op.raw;
    ctrlWord[ctrlCarryBit]               = carryIn;
    ctrlWord[ctrlBusyBit]                = busy;
    ctrlWord[ctrlFlagsLsb +: flagsWidth] = flags;
  end

  always_comb begin
    case (wbAdr)
      regA:      rdData = opA;
      regB:      rdData = opB;
      regRdLo:   rdData = rdLo;
      regRdHiRa: rdData = rdHiRa;
      regCbzRn:  rdData = cbzRn;
      regCtrl:   rdData = ctrlWord;
      regResLo:  rdData = resLo;
      regResHi:  rdData = resHi;
      default:   rdData = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbAck   <= 1'b0;
      wbDatR  <= '0;
      start   <= 1'b0;
      op      <= '0;
      carryIn <= 1'b0;
      opA     <= '0;
      opB     <= '0;
      rdLo    <= '0;
      rdHiRa  <= '0;
      cbzRn   <= '0;
    end else begin
      wbAck <= newReq;
      start <= 1'b0;
      if (newReq) begin
        wbDatR <= rdData;
      end
      // Writes while busy are acknowledged and dropped
      if (wrAcc && !lock) begin
        case (wbAdr)
          regA:      opA    <= wbDatW;
          regB:      opB    <= wbDatW;
          regRdLo:   rdLo   <= wbDatW;
          regRdHiRa: rdHiRa <= wbDatW;
          regCbzRn:  cbzRn  <= wbDatW;
          regCtrl: begin
            op.raw  <= wbDatW[ctrlOpLsb +: opWidth];
            carryIn <= wbDatW[ctrlCarryBit];
            start   <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* src/aluCop.sv */
module aluCop (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         wbCyc,
  input  logic                         wbStb,
  input  logic                         wbWe,
  input  logic [2:0]                   wbAdr,
  input  logic [aluPkg::dataWidth-1:0] wbDatW,
  output logic [aluPkg::dataWidth-1:0] wbDatR,
  output logic                         wbAck
);
  import aluPkg::*;

  // Register block to sequencer
  logic                  start;
  aluOpU                 op;
  logic                  carryIn;
  logic [dataWidth-1:0]  opA;
  logic [dataWidth-1:0]  opB;
  logic [dataWidth-1:0]  rdLo;
  logic [dataWidth-1:0]  rdHiRa;
  logic [dataWidth-1:0]  cbzRn;

  // Sequencer back to register block
  logic                  busy;
  logic [dataWidth-1:0]  resLo;
  logic [dataWidth-1:0]  resHi;
  logic [flagsWidth-1:0] flags;

  aluRegs uRegs (
    .clk     (clk),
    .arstN   (arstN),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAdr   (wbAdr),
    .wbDatW  (wbDatW),
    .busy    (busy),
    .resLo   (resLo),
    .resHi   (resHi),
    .flags   (flags),
    .wbDatR  (wbDatR),
    .wbAck   (wbAck),
    .start   (start),
    .op      (op),
    .carryIn (carryIn),
    .opA     (opA),
    .opB     (opB),
    .rdLo    (rdLo),
    .rdHiRa  (rdHiRa),
    .cbzRn   (cbzRn)
  );

  aluExec uExec (
    .clk     (clk),
    .arstN   (arstN),
    .start   (start),
    .carryIn (carryIn),
    .op      (op),
    .opA     (opA),
    .opB     (opB),
    .rdLo    (rdLo),
    .rdHiRa  (rdHiRa),
    .cbzRn   (cbzRn),
    .busy    (busy),
    .resLo   (resLo),
    .resHi   (resHi),
    .flags   (flags)
  );

endmodule

/* verif/aluCop_assert.sv */
module aluCopAssert (
  input logic clk,
  input logic arstN,
  input logic start,
  input logic busy,
  input logic divStart,
  input logic divDone,
  input logic wbAck
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  // New operation only from idle
  startIdle: assert property (@(posedge clk) disable iff (!arstN) start |-> !busy)
    else begin
      failCount++;
      $error("start pulse seen while the sequencer was busy");
    end

  divLatency: assert property (@(posedge clk) disable iff (!arstN) divStart |-> ##33 divDone)
    else begin
      failCount++;
      $error("divider done did not arrive 33 cycles after its start");
    end

  // Slave never holds ack for two cycles
  ackPulse: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
    else begin
      failCount++;
      $error("bus acknowledge lasted more than one cycle");
    end

endmodule

bind aluCop aluCopAssert uAssert (
  .clk      (clk),
  .arstN    (arstN),
  .start    (start),
  .busy     (busy),
  .divStart (uExec.divStart),
  .divDone  (uExec.divDone),
  .wbAck    (wbAck)
);

/* verif/aluCopTb.sv */
module aluCopTb;
  timeunit 1ns;
  timeprecision 100ps;
  import aluPkg::*;

  localparam int maxPatterns = 64;
  localparam int patWords    = 10;
  localparam int ackLimit    = 16;
  localparam int pollLimit   = 100;

  logic        clk;
  logic        arstN;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  logic [2:0]  wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic        wbAck;

  // Ten words per pattern in the column order of the pattern file
  logic [31:0] patMem [0:maxPatterns*patWords-1];
  int          numPatterns;
  int          errorCount;
  int          checkCount;
  bit          loaded;

  aluCop UUT (
    .clk    (clk),
    .arstN  (arstN),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  always #5 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected)
    else begin
      errorCount++;
      $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  // One classic cycle with inputs changed 1 ns after the edge
  task automatic busCycle(input bit write, input logic [2:0] adr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = write;
    wbAdr  = adr;
    wbDatW = wdata;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wbAck && waited < ackLimit);
    rdata = wbDatR;
    assert (wbAck)
    else begin
      errorCount++;
      $display("Bus cycle to address %0d got no acknowledge within %0d cycles", adr, ackLimit);
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic busWrite(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] discard;
    busCycle(1'b1, adr, data, discard);
  endtask

  task automatic busRead(input logic [2:0] adr, output logic [31:0] data);
    busCycle(1'b0, adr, '0, data);
  endtask

  // Poll the status word until busy clears
  task automatic waitIdle(input string name);
    logic [31:0] status;
    int          polls;
    polls = 0;
    do begin
      busRead(regCtrl, status);
      polls++;
    end while (status[ctrlBusyBit] && polls < pollLimit);
    assert (!status[ctrlBusyBit])
    else begin
      errorCount++;
      $display("%s: busy still set after %0d status reads", name, pollLimit);
    end
  endtask

  task automatic runPattern(input int idx);
    int          base;
    int          k;
    logic [5:0]  opCode;
    logic        carry;
    logic [31:0] rd;
    logic [31:0] ctrlWord;
    logic [31:0] ctrlExp;
    bit          isDiv;
    string       name;
    base   = idx * patWords;
    opCode = patMem[base][5:0];
    carry  = patMem[base+1][0];
    isDiv  = (opCode == opUdiv) || (opCode == opSdiv);
    name   = $sformatf("pattern %0d op %02h", idx, opCode);
    // Operand words map to addresses 0 to 4 in file order
    for (k = 0; k < 5; k++) begin
      busWrite(3'(k), patMem[base+2+k]);
    end
    for (k = 0; k < 5; k++) begin
      busRead(3'(k), rd);
      checkValue($sformatf("%s operand %0d readback", name, k), patMem[base+2+k], rd);
    end
    ctrlWord = '0;
    ctrlWord[ctrlOpLsb +: opWidth] = opCode;
    ctrlWord[ctrlCarryBit]         = carry;
    busWrite(regCtrl, ctrlWord);
    if (isDiv) begin
      // Both writes land while the divider runs and must be dropped
      busWrite(regCtrl, 32'(opAdd));
      busWrite(regA, ~patMem[base+2]);
    end
    waitIdle(name);
    busRead(regResLo, rd);
    checkValue({name, " resLo"}, patMem[base+7], rd);
    busRead(regResHi, rd);
    checkValue({name, " resHi"}, patMem[base+8], rd);
    // Expect busy low with the op, carry and flags of this operation
    ctrlExp = ctrlWord;
    ctrlExp[ctrlFlagsLsb +: flagsWidth] = patMem[base+9][flagsWidth-1:0];
    busRead(regCtrl, rd);
    checkValue({name, " control word"}, ctrlExp, rd);
    if (isDiv) begin
      busRead(regA, rd);
      checkValue({name, " operand A after write while busy"}, patMem[base+2], rd);
    end
  endtask

  initial begin
    int          i;
    int          assertFails;
    logic [31:0] rd;
    clk         = 1'b0;
    arstN       = 1'b0;
    wbCyc       = 1'b0;
    wbStb       = 1'b0;
    wbWe        = 1'b0;
    wbAdr       = '0;
    wbDatW      = '0;
    errorCount  = 0;
    checkCount  = 0;
    loaded      = 1'b0;
    for (i = 0; i < maxPatterns * patWords; i++) begin
      patMem[i] = '1;
    end
    $readmemh("verif/aluPatterns.hex", patMem);
    numPatterns = 0;
    while (numPatterns < maxPatterns && patMem[numPatterns*patWords] != '1) begin
      numPatterns++;
    end
    loaded = 1'b1;
    assert (numPatterns > 0)
    else begin
      errorCount++;
      $display("No patterns were loaded from the pattern file");
    end
    repeat (10) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Every register reads zero out of reset
    for (i = 0; i < 8; i++) begin
      busRead(3'(i), rd);
      checkValue($sformatf("reset value of register %0d", i), 32'h0, rd);
    end
    for (i = 0; i < numPatterns; i++) begin
      runPattern(i);
    end
    assertFails = UUT.uAssert.failCount;
    $display("Patterns: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             numPatterns, checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // 60 cycles per pattern plus reset and margin
  initial begin
    int limit;
    wait (loaded);
    limit = numPatterns * 60 + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, simulation stopped", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verif/aluPatterns.hex */
// op carry A B RdLo RdHiRa CbzRn expResLo expResHi expFlags
// flags from bit 4 down: saturated negative zero carry overflow
// Add and subtract forms
20 0 7fffffff 00000001 00000000 00000000 00000000 80000000 00000000 09
20 0 ffffffff 00000001 00000000 00000000 00000000 00000000 00000000 06
21 0 00000010 00000020 00000000 00000000 00000000 00000030 00000000 00
21 1 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 06
22 0 7ffffff0 00000100 00000000 00000000 00000000 7fffffff 00000000 11
22 0 80000000 ffffffff 00000000 00000000 00000000 80000000 00000000 19
23 0 00000005 00000007 00000000 00000000 00000000 fffffffe 00000000 0a
23 0 00000009 00000009 00000000 00000000 00000000 00000000 00000000 04
24 1 00000010 00000004 00000000 00000000 00000000 0000000c 00000000 00
24 0 00000004 00000004 00000000 00000000 00000000 ffffffff 00000000 0a
25 0 00000003 00000010 00000000 00000000 00000000 0000000d 00000000 00
26 0 80000000 00000001 00000000 00000000 00000000 80000000 00000000 19
26 0 7fffffff ffffffff 00000000 00000000 00000000 7fffffff 00000000 11
// Logic, compare and move
30 0 f0f0f0f0 ff00ff00 00000000 00000000 00000000 f000f000 00000000 08
31 0 f0f0f0f0 ff00ff00 00000000 00000000 00000000 00f000f0 00000000 00
32 0 12340000 00005678 00000000 00000000 00000000 12345678 00000000 00
33 0 00000000 ffffffff 00000000 00000000 00000000 00000000 00000000 04
34 0 aaaaaaaa 55555555 00000000 00000000 00000000 ffffffff 00000000 08
3f 0 0000ffff 00ff00ff 00000000 00000000 00000000 ff0000ff 00000000 08
35 0 ffffffff 00000002 00000000 00000000 00000000 00000001 00000000 02
36 0 0f0f0f0f f0f0f0f0 00000000 00000000 00000000 00000000 00000000 04
38 0 00000003 00000005 00000000 00000000 00000000 fffffffe 00000000 0a
39 0 12345678 80000000 00000000 00000000 00000000 80000000 00000000 08
// Shifts and rotates
3c 0 80000001 00000001 00000000 00000000 00000000 00000002 00000000 02
3a 0 00000003 00000001 00000000 00000000 00000000 00000001 00000000 02
3b 0 80000000 00000004 00000000 00000000 00000000 f8000000 00000000 08
3d 0 00000008 00000004 00000000 00000000 00000000 80000000 00000000 0a
3e 1 00000003 00000000 00000000 00000000 00000000 80000001 00000000 0a
// Multiply and multiply-accumulate
27 0 00010001 00010001 00000000 00000000 00000000 00020001 00000000 00
28 0 00000003 00000004 00000000 00000064 00000000 00000070 00000000 00
29 0 00000003 00000004 00000000 0000000a 00000000 fffffffe 00000000 08
2a 0 ffffffff ffffffff 00000000 00000000 00000000 00000001 fffffffe 00
2b 0 00000002 80000000 ffffffff 00000001 00000000 ffffffff 00000002 08
2c 0 fffffffe 00000003 00000000 00000000 00000000 fffffffa ffffffff 08
2d 0 ffffffff 00000005 00000005 00000000 00000000 00000000 00000000 04
// Division
2e 0 00000064 00000007 00000000 00000000 00000000 0000000e 00000000 00
2e 0 ffffffff 00000010 00000000 00000000 00000000 0fffffff 00000000 00
2e 0 12345678 00000000 00000000 00000000 00000000 00000000 00000000 04
2f 0 ffffff9c 00000007 00000000 00000000 00000000 fffffff2 00000000 08
2f 0 00000064 fffffff9 00000000 00000000 00000000 fffffff2 00000000 08
2f 0 ffffff9c fffffff9 00000000 00000000 00000000 0000000e 00000000 00
2f 0 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 04
// Branch target selection
10 0 00001000 00000020 00000000 00000000 00000000 00001020 00000000 00
12 0 00001000 00000040 00000000 00000000 00000000 00001040 00000000 00
12 0 00001000 00000040 00000000 00000000 00000005 00001000 00000000 00
13 0 00001000 00000040 00000000 00000000 00000005 00001040 00000000 00
13 0 00001000 00000040 00000000 00000000 00000000 00001000 00000000 00

/* vlog.f */
src/aluPkg.sv
src/alu.sv
src/seqDivider.sv
src/aluExec.sv
src/aluRegs.sv
src/aluCop.sv
verif/aluCop_assert.sv
verif/aluCopTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= aluCopTb
LINT_TOP  ?= aluCop
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
